// ==== Bender.yml ====
package:
  name: obj_gfx

sources:
  - files:
      - source/obj_pkg.sv
      - source/obj_attr_table.sv
      - source/obj_line_engine.sv
      - source/obj_line_buffer.sv
      - source/obj_gfx_top.sv
  - target: test
    files:
      - verification/obj_gfx_assert.sv
      - verification/obj_gfx_tb.sv

// ==== compile.f ====
source/obj_pkg.sv
source/obj_attr_table.sv
source/obj_line_engine.sv
source/obj_line_buffer.sv
source/obj_gfx_top.sv
verification/obj_gfx_assert.sv
verification/obj_gfx_tb.sv

// ==== source/obj_attr_table.sv ====
module obj_attr_table (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [11:0]                   awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [31:0]                   wdata,
    input  logic [3:0]                    wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [11:0]                   araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [31:0]                   rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready,
    input  logic [obj_pkg::obj_idx_w-1:0] rec_idx,
    output obj_pkg::obj_attr_t            rec
);

    obj_pkg::obj_attr_t mem [obj_pkg::obj_count];

    logic                          wr_fire;
    logic                          rd_fire;
    logic                          aw_bad;
    logic                          ar_bad;
    logic [obj_pkg::obj_idx_w-1:0] aw_idx;
    logic [obj_pkg::obj_idx_w-1:0] ar_idx;
    logic [31:0]                   old_word;
    logic [31:0]                   new_word;

    // host view of one record half, unused bits read as zero
    function automatic logic [31:0] rec_word(obj_pkg::obj_attr_t r, logic hi);
        if (hi) begin
            return {15'd0, r.enable, 5'd0, r.size, r.xpos};
        end
        return {r.ypos, 4'd0, r.pal, 2'd0, r.code};
    endfunction

    function automatic obj_pkg::obj_attr_t rec_merge(obj_pkg::obj_attr_t r, logic hi,
                                                     logic [31:0] w);
        obj_pkg::obj_attr_t m;
        m = r;
        if (hi) begin
            m.xpos   = w[7:0];
            m.size   = obj_pkg::obj_size_e'(w[10:8]);
            m.enable = w[16];
        end else begin
            m.code = w[13:0];
            m.pal  = w[19:16];
            m.ypos = w[31:24];
        end
        return m;
    endfunction

    assign wr_fire = awvalid && wvalid && !bvalid;  // aw and w taken together
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign arready = !rvalid;
    assign rd_fire = arvalid && arready;

    assign aw_bad = awaddr >= 12'(obj_pkg::tbl_bytes);
    assign ar_bad = araddr >= 12'(obj_pkg::tbl_bytes);
    assign aw_idx = awaddr[3 +: obj_pkg::obj_idx_w];
    assign ar_idx = araddr[3 +: obj_pkg::obj_idx_w];

    always_comb begin
        old_word = rec_word(mem[aw_idx], awaddr[2]);
        for (int i = 0; i < 4; i++) begin
            new_word[8*i +: 8] = wstrb[i] ? wdata[8*i +: 8] : old_word[8*i +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < obj_pkg::obj_count; i++) begin
                mem[i].enable <= 1'b0;              // all sprites off
            end
        end else if (wr_fire && !aw_bad) begin
            mem[aw_idx] <= rec_merge(mem[aw_idx], awaddr[2], new_word);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        rec <= mem[rec_idx];                        // engine port
        if (wr_fire) begin
            bresp <= aw_bad ? obj_pkg::axi_slverr : obj_pkg::axi_okay;
        end
        if (rd_fire) begin
            rresp <= ar_bad ? obj_pkg::axi_slverr : obj_pkg::axi_okay;
            rdata <= ar_bad ? 32'd0 : rec_word(mem[ar_idx], araddr[2]);
        end
    end

endmodule

// ==== source/obj_gfx_top.sv ====
module obj_gfx_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [11:0]                    awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [31:0]                    wdata,
    input  logic [3:0]                     wstrb,
    input  logic                           wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  logic                           bready,
    input  logic [11:0]                    araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output logic [31:0]                    rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  logic                           rready,
    input  logic                           start,
    input  logic                           lvbl,
    input  logic [obj_pkg::line_w-1:0]     vrender,
    output logic                           done,
    output logic                           rom_cs,
    output logic [obj_pkg::rom_addr_w-1:0] rom_addr,
    input  logic                           rom_ok,
    input  logic [15:0]                    rom_data,
    input  logic [obj_pkg::line_w-1:0]     pxl_addr,
    output logic [7:0]                     pxl_data
);

    logic [obj_pkg::obj_idx_w-1:0] rec_idx;
    obj_pkg::obj_attr_t            rec;
    obj_pkg::rom_req_t             rom_req;
    obj_pkg::pxl_wr_t              pxl_wr;
    logic                          pxl_wr_valid;
    logic                          swap;

    assign rom_addr = rom_req.addr;

    obj_attr_table u_table (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .rec_idx (rec_idx),
        .rec     (rec)
    );

    obj_line_engine u_engine (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .lvbl         (lvbl),
        .vrender      (vrender),
        .rec          (rec),
        .rom_ok       (rom_ok),
        .rom_data     (rom_data),
        .rec_idx      (rec_idx),
        .rom_cs       (rom_cs),
        .rom_req      (rom_req),
        .pxl_wr       (pxl_wr),
        .pxl_wr_valid (pxl_wr_valid),
        .done         (done),
        .swap         (swap)
    );

    obj_line_buffer u_buffer (
        .clk          (clk),
        .rst          (rst),
        .swap         (swap),
        .pxl_wr       (pxl_wr),
        .pxl_wr_valid (pxl_wr_valid),
        .pxl_addr     (pxl_addr),
        .pxl_data     (pxl_data)
    );

endmodule

// ==== source/obj_line_buffer.sv ====
module obj_line_buffer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       swap,
    input  obj_pkg::pxl_wr_t           pxl_wr,
    input  logic                       pxl_wr_valid,
    input  logic [obj_pkg::line_w-1:0] pxl_addr,
    output logic [7:0]                 pxl_data
);

    logic                                sel;       // front half index
    logic [1:0][obj_pkg::line_len-1:0]   vld;
    logic [7:0]                          buf_mem [2][obj_pkg::line_len];
    logic                                wr_en;

    assign wr_en = pxl_wr_valid && (pxl_wr.colour[3:0] != 4'd0);   // zero nibble is clear

    // an entry with its valid bit low reads as zero, so clearing
    // one bit empties the entry and reset empties both halves
    always_ff @(posedge clk) begin
        if (rst) begin
            sel <= 1'b0;
            vld <= '0;
        end else begin
            if (swap) begin
                sel <= ~sel;
            end
            vld[sel][pxl_addr] <= 1'b0;             // clear on read
            if (wr_en) begin
                vld[~sel][pxl_wr.x] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        pxl_data <= vld[sel][pxl_addr] ? buf_mem[sel][pxl_addr] : 8'h00;
        if (wr_en) begin
            buf_mem[~sel][pxl_wr.x] <= pxl_wr.colour;   // back half only
        end
    end

endmodule

// ==== source/obj_line_engine.sv ====
module obj_line_engine (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic                          lvbl,
    input  logic [obj_pkg::line_w-1:0]    vrender,
    input  obj_pkg::obj_attr_t            rec,
    input  logic                          rom_ok,
    input  logic [15:0]                   rom_data,
    output logic [obj_pkg::obj_idx_w-1:0] rec_idx,
    output logic                          rom_cs,
    output obj_pkg::rom_req_t             rom_req,
    output obj_pkg::pxl_wr_t              pxl_wr,
    output logic                          pxl_wr_valid,
    output logic                          done,
    output logic                          swap
);

    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_test,
        st_fetch,
        st_dump,
        st_next
    } state_e;

    state_e                     st;
    logic                       last_start;
    logic [13:0]                code;
    logic [3:0]                 pal;
    logic [4:0]                 row;
    logic [2:0]                 w_tiles;
    logic [4:0]                 col;
    logic [obj_pkg::line_w-1:0] pix_x;
    logic [15:0]                pix_shift;
    logic [1:0]                 dump_cnt;
    logic [obj_pkg::line_w-1:0] row_full;
    logic [2:0]                 h_tiles;
    logic                       hit;
    logic [3:0]                 tile;
    logic                       last_word;

    assign done = (st == st_idle);
    assign swap = start && !last_start && lvbl && done;   // edges mid-scan ignored

    // vertical hit test on the record just read
    assign row_full = vrender - {1'b0, rec.ypos};
    assign h_tiles  = obj_pkg::size_h_tiles(rec.size);
    assign hit      = rec.enable && (vrender >= {1'b0, rec.ypos}) &&
                      (row_full < {3'b000, h_tiles, 3'b000});

    assign tile      = {2'b00, row[4:3]} * {1'b0, w_tiles} + {2'b00, col[4:3]};
    assign last_word = ({1'b0, col[4:2]} == ({w_tiles, 1'b0} - 4'd1));

    // derived from registers only, so it holds while rom_cs waits
    assign rom_req.addr = {code + {10'd0, tile}, row[2:0], col[2]};

    always_ff @(posedge clk) begin
        if (rst) begin
            st           <= st_idle;
            last_start   <= 1'b0;
            rec_idx      <= '0;
            rom_cs       <= 1'b0;
            pxl_wr_valid <= 1'b0;
        end else begin
            last_start   <= start;
            pxl_wr_valid <= 1'b0;
            case (st)
                st_idle: begin
                    if (swap) begin
                        rec_idx <= '0;
                        st      <= st_read;
                    end
                end
                st_read: begin
                    st <= st_test;                  // record arrives next cycle
                end
                st_test: begin
                    code    <= rec.code;
                    pal     <= rec.pal;
                    row     <= row_full[4:0];
                    w_tiles <= obj_pkg::size_w_tiles(rec.size);
                    col     <= 5'd0;
                    pix_x   <= {1'b0, rec.xpos};
                    if (hit) begin
                        rom_cs <= 1'b1;
                        st     <= st_fetch;
                    end else begin
                        st <= st_next;
                    end
                end
                st_fetch: begin
                    if (rom_ok) begin
                        pix_shift <= rom_data;
                        rom_cs    <= 1'b0;
                        dump_cnt  <= 2'd0;
                        st        <= st_dump;
                    end
                end
                st_dump: begin
                    pxl_wr.x      <= pix_x;
                    pxl_wr.colour <= {pal, pix_shift[15:12]};
                    pxl_wr_valid  <= 1'b1;
                    pix_shift     <= pix_shift << 4;
                    pix_x         <= pix_x + 1'b1;
                    dump_cnt      <= dump_cnt + 1'b1;
                    if (dump_cnt == 2'd3) begin
                        if (last_word) begin
                            st <= st_next;
                        end else begin
                            col    <= col + 5'd4;   // next half tile
                            rom_cs <= 1'b1;
                            st     <= st_fetch;
                        end
                    end
                end
                st_next: begin
                    if (rec_idx == obj_pkg::obj_idx_w'(obj_pkg::obj_count - 1)) begin
                        st <= st_idle;
                    end else begin
                        rec_idx <= rec_idx + 1'b1;
                        st      <= st_read;
                    end
                end
                default: st <= st_idle;
            endcase
        end
    end

endmodule

// ==== source/obj_pkg.sv ====
package obj_pkg;

    localparam int obj_count  = 64;
    localparam int obj_idx_w  = 6;
    localparam int line_w     = 9;
    localparam int line_len   = 1 << line_w;        // entries per line buffer half
    localparam int rom_addr_w = 18;
    localparam int tbl_bytes  = obj_count * 8;      // two words per record

    localparam logic [1:0] axi_okay   = 2'b00;
    localparam logic [1:0] axi_slverr = 2'b10;

    typedef enum logic [2:0] {
        size_16x16 = 3'd0,
        size_16x8  = 3'd1,
        size_8x16  = 3'd2,
        size_8x8   = 3'd3,
        size_32x32 = 3'd4
    } obj_size_e;

    typedef struct packed {
        logic [1:0]  spare;
        logic        enable;
        obj_size_e   size;
        logic [7:0]  xpos;
        logic [7:0]  ypos;
        logic [3:0]  pal;
        logic [13:0] code;                          // first tile number
    } obj_attr_t;

    typedef struct packed {
        logic [rom_addr_w-1:0] addr;
    } rom_req_t;

    typedef struct packed {
        logic [line_w-1:0] x;
        logic [7:0]        colour;                  // pal on top, pixel nibble below
    } pxl_wr_t;

    // sprite width in 8-pixel tiles, codes 5 to 7 act as 16x16
    function automatic logic [2:0] size_w_tiles(obj_size_e s);
        case (s)
            size_8x16, size_8x8: return 3'd1;
            size_32x32:          return 3'd4;
            default:             return 3'd2;
        endcase
    endfunction

    function automatic logic [2:0] size_h_tiles(obj_size_e s);
        case (s)
            size_16x8, size_8x8: return 3'd1;
            size_32x32:          return 3'd4;
            default:             return 3'd2;
        endcase
    endfunction

endpackage

// ==== verification/obj_gfx_assert.sv ====
module obj_gfx_assert (
    input logic              clk,
    input logic              rst,
    input logic              rom_cs,
    input logic              rom_ok,
    input obj_pkg::rom_req_t rom_req,
    input logic              done
);

    // request held with a fixed address until the ROM answers
    property req_held;
        @(posedge clk) disable iff (rst)
            rom_cs && !rom_ok |=> rom_cs && $stable(rom_req);
    endproperty

    property req_drops;
        @(posedge clk) disable iff (rst) rom_cs && rom_ok |=> !rom_cs;
    endproperty

    property idle_quiet;
        @(posedge clk) disable iff (rst) done |-> !rom_cs;
    endproperty

    assert property (req_held) else $error("rom request changed before rom_ok");
    assert property (req_drops) else $error("rom_cs still high after rom_ok");
    assert property (idle_quiet) else $error("rom_cs high while engine is idle");

endmodule

bind obj_line_engine obj_gfx_assert u_assert (
    .clk     (clk),
    .rst     (rst),
    .rom_cs  (rom_cs),
    .rom_ok  (rom_ok),
    .rom_req (rom_req),
    .done    (done)
);

// ==== verification/obj_gfx_tb.sv ====
module obj_gfx_tb;

    localparam int axi_limit  = 100;
    localparam int scan_limit = 40000;
    localparam int idle_line  = 500;                // below every sprite

    logic        clk;
    logic        rst;
    logic [11:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [11:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        start;
    logic        lvbl;
    logic [8:0]  vrender;
    logic        done;
    logic        rom_cs;
    logic [17:0] rom_addr;
    logic        rom_ok = 1'b0;
    logic [15:0] rom_data = 16'd0;
    logic [8:0]  pxl_addr;
    logic [7:0]  pxl_data;

    integer             seed = 75938;
    int                 errors = 0;
    int                 checks = 0;
    logic               rom_busy = 1'b0;
    int                 rom_cnt;
    obj_pkg::obj_attr_t shadow [obj_pkg::obj_count];      // host view of the table
    logic [7:0]         exp_line [obj_pkg::line_len];
    logic [7:0]         got_line [obj_pkg::line_len];

    obj_gfx_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ROM contents are a fixed scramble of the address with small nibbles forced to zero
    function automatic logic [15:0] rom_hash(input logic [17:0] a);
        logic [31:0] h;
        logic [15:0] w;
        h = {14'd0, a} * 32'h9e3779b1;
        w = h[31:16] ^ h[15:0];
        for (int i = 0; i < 4; i++) begin
            if (w[4*i +: 4] < 4'd3) begin
                w[4*i +: 4] = 4'd0;
            end
        end
        return w;
    endfunction

    // ROM answers 1 to 4 cycles after it sees a request
    always @(posedge clk) begin
        if (rst) begin
            rom_ok   <= 1'b0;
            rom_busy <= 1'b0;
        end else begin
            rom_ok <= 1'b0;
            if (rom_busy) begin
                if (rom_cnt == 1) begin
                    rom_ok   <= 1'b1;
                    rom_data <= rom_hash(rom_addr);
                    rom_busy <= 1'b0;
                end else begin
                    rom_cnt <= rom_cnt - 1;
                end
            end else if (rom_cs && !rom_ok) begin
                rom_busy <= 1'b1;
                rom_cnt  <= 1 + ($unsigned($random(seed)) % 4);
            end
        end
    end

    task automatic log_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_pixel(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // width and height in pixels with unknown codes drawn as 16x16
    task automatic obj_dims(input logic [2:0] s, output int w, output int h);
        case (s)
            3'd1: begin
                w = 16;
                h = 8;
            end
            3'd2: begin
                w = 8;
                h = 16;
            end
            3'd3: begin
                w = 8;
                h = 8;
            end
            3'd4: begin
                w = 32;
                h = 32;
            end
            default: begin
                w = 16;
                h = 16;
            end
        endcase
    endtask

    function automatic logic [31:0] field_word(input obj_pkg::obj_attr_t r, input logic hi);
        logic [31:0] w;
        w = 32'd0;
        if (hi) begin
            w[7:0]  = r.xpos;
            w[10:8] = r.size;
            w[16]   = r.enable;
        end else begin
            w[13:0]  = r.code;
            w[19:16] = r.pal;
            w[31:24] = r.ypos;
        end
        return w;
    endfunction

    task automatic store_word(input int idx, input logic hi, input logic [31:0] w);
        if (hi) begin
            shadow[idx].xpos   = w[7:0];
            shadow[idx].size   = obj_pkg::obj_size_e'(w[10:8]);
            shadow[idx].enable = w[16];
        end else begin
            shadow[idx].code = w[13:0];
            shadow[idx].pal  = w[19:16];
            shadow[idx].ypos = w[31:24];
        end
    endtask

    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        int t;
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!(awready && wready) && t < axi_limit);
        if (!(awready && wready)) begin
            log_failure($sformatf("write to %h was never accepted", addr));
        end
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        t = 0;
        while (!bvalid && t < axi_limit) begin
            @(negedge clk);
            t++;
        end
        if (!bvalid) begin
            log_failure($sformatf("no write response for %h", addr));
        end
        resp = bresp;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int t;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!arready && t < axi_limit);
        if (!arready) begin
            log_failure($sformatf("read of %h was never accepted", addr));
        end
        @(posedge clk);
        arvalid <= 1'b0;
        t = 0;
        while (!rvalid && t < axi_limit) begin
            @(negedge clk);
            t++;
        end
        if (!rvalid) begin
            log_failure($sformatf("no read data for %h", addr));
        end
        data = rdata;
        resp = rresp;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    // host write that also keeps the shadow table in step
    task automatic put_word(input logic [11:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
        logic [1:0]  resp;
        logic [31:0] merged;
        int          idx;
        idx = addr[8:3];
        axi_write(addr, data, strb, resp);
        check_resp($sformatf("write %h", addr), obj_pkg::axi_okay, resp);
        merged = field_word(shadow[idx], addr[2]);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        store_word(idx, addr[2], merged);
    endtask

    task automatic set_rec(input int idx, input logic [13:0] code, input logic [3:0] pal,
                           input logic [7:0] ypos, input logic [7:0] xpos,
                           input logic [2:0] size, input logic en);
        put_word(12'(8 * idx), {ypos, 4'd0, pal, 2'd0, code}, 4'hf);
        put_word(12'(8 * idx + 4), {15'd0, en, 5'd0, size, xpos}, 4'hf);
    endtask

    task automatic clear_table();
        for (int i = 0; i < obj_pkg::obj_count; i++) begin
            put_word(12'(8 * i + 4), 32'd0, 4'hf);
        end
    endtask

    task automatic run_line(input int v);
        int t;
        @(posedge clk);
        vrender <= 9'(v);
        lvbl    <= 1'b1;
        start   <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        if (done) begin
            log_failure($sformatf("scan for line %0d did not start", v));
        end
        t = 0;
        while (!done && t < scan_limit) begin
            @(negedge clk);
            t++;
        end
        if (!done) begin
            log_failure($sformatf("timeout waiting for done on line %0d", v));
        end
    endtask

    // reads all entries and then parks the address on an entry no sprite reaches
    task automatic read_line();
        for (int i = 0; i <= obj_pkg::line_len; i++) begin
            @(posedge clk);
            pxl_addr <= (i < obj_pkg::line_len) ? 9'(i) : 9'd511;
            @(negedge clk);
            if (i > 0) begin
                got_line[i-1] = pxl_data;
            end
        end
    endtask

    task automatic model_line(input int v);
        int          w;
        int          h;
        int          r;
        logic [13:0] tcode;
        logic [15:0] word;
        logic [3:0]  nib;
        for (int x = 0; x < obj_pkg::line_len; x++) begin
            exp_line[x] = 8'h00;
        end
        for (int i = 0; i < obj_pkg::obj_count; i++) begin
            obj_dims(shadow[i].size, w, h);
            if (shadow[i].enable && v >= shadow[i].ypos && v < shadow[i].ypos + h) begin
                r = v - shadow[i].ypos;
                for (int c = 0; c < w; c++) begin
                    tcode = shadow[i].code + 14'((r / 8) * (w / 8) + c / 8);
                    word  = rom_hash({tcode, 3'(r % 8), 1'((c % 8) / 4)});
                    nib   = word[15 - 4 * (c % 4) -: 4];
                    if (nib != 4'd0) begin
                        exp_line[shadow[i].xpos + c] = {shadow[i].pal, nib};  // later wins
                    end
                end
            end
        end
    endtask

    task automatic compare_line(input string name);
        for (int x = 0; x < obj_pkg::line_len; x++) begin
            check_pixel($sformatf("%s x=%0d", name, x), exp_line[x], got_line[x]);
        end
    endtask

    task automatic expect_blank(input string name);
        for (int x = 0; x < obj_pkg::line_len; x++) begin
            exp_line[x] = 8'h00;
        end
        read_line();
        compare_line(name);
    endtask

    // render into the back half and swap it to the front with an empty scan before reading
    task automatic render_check(input string name, input int v);
        run_line(v);
        run_line(idle_line);
        read_line();
        model_line(v);
        compare_line($sformatf("%s line %0d", name, v));
    endtask

    task automatic test_reset();
        if (done !== 1'b1) begin
            log_failure("done is not high after reset");
        end
        if (rom_cs !== 1'b0) begin
            log_failure("rom_cs is not low after reset");
        end
        if (bvalid !== 1'b0 || rvalid !== 1'b0) begin
            log_failure("an AXI valid output is high after reset");
        end
        expect_blank("reset front");
        run_line(idle_line);
        expect_blank("reset back");
    endtask

    task automatic test_axi_regs();
        int          idx_list [3] = '{0, 17, 63};
        logic [1:0]  resp;
        logic [31:0] data;
        set_rec(0, 14'h1234, 4'h5, 8'h21, 8'h43, 3'd4, 1'b1);
        set_rec(17, 14'h3fff, 4'hf, 8'hff, 8'hff, 3'd7, 1'b1);
        set_rec(63, 14'h0001, 4'h1, 8'h10, 8'h80, 3'd2, 1'b0);
        put_word(12'h000, 32'hffff_ffff, 4'b0010);      // byte 1 only
        put_word(12'h1fc, 32'hffff_ffff, 4'hf);         // unused bits must stay zero
        axi_write(12'h200, 32'hffff_ffff, 4'hf, resp);
        check_resp("write 200", obj_pkg::axi_slverr, resp);
        axi_write(12'hffc, 32'h0000_0000, 4'hf, resp);  // aliases record 63 high word
        check_resp("write ffc", obj_pkg::axi_slverr, resp);
        axi_read(12'h204, data, resp);
        check_resp("read 204", obj_pkg::axi_slverr, resp);
        check_word("read 204", 32'd0, data);
        foreach (idx_list[k]) begin
            for (int hi = 0; hi < 2; hi++) begin
                axi_read(12'(8 * idx_list[k] + 4 * hi), data, resp);
                check_resp($sformatf("read rec %0d.%0d", idx_list[k], hi),
                           obj_pkg::axi_okay, resp);
                check_word($sformatf("read rec %0d.%0d", idx_list[k], hi),
                           field_word(shadow[idx_list[k]], hi[0]), data);
            end
        end
    endtask

    task automatic test_single();
        clear_table();
        set_rec(5, 14'h0040, 4'h7, 8'd40, 8'd100, 3'd3, 1'b1);
        render_check("single 8x8", 44);
    endtask

    task automatic test_sizes();
        int w;
        int h;
        clear_table();
        for (int s = 0; s < 5; s++) begin
            obj_dims(3'(s), w, h);
            set_rec(10, 14'(16'h0200 + 16 * s), 4'h3, 8'd60, 8'd30, 3'(s), 1'b1);
            render_check($sformatf("size %0d", s), 59);
            render_check($sformatf("size %0d", s), 60);
            render_check($sformatf("size %0d", s), 60 + h / 2 + 1);
            render_check($sformatf("size %0d", s), 60 + h - 1);
            render_check($sformatf("size %0d", s), 60 + h);
        end
    endtask

    task automatic test_overlap();
        clear_table();
        set_rec(3, 14'h0100, 4'h2, 8'd100, 8'd50, 3'd0, 1'b1);
        set_rec(7, 14'h0180, 4'h9, 8'd104, 8'd58, 3'd0, 1'b1);
        render_check("overlap", 103);
        render_check("overlap", 106);
        render_check("overlap", 115);
    endtask

    task automatic test_random();
        logic [31:0] rnd;
        for (int i = 0; i < obj_pkg::obj_count; i++) begin
            rnd = $random(seed);
            set_rec(i, rnd[13:0], rnd[19:16], 8'($unsigned($random(seed)) % 96),
                    rnd[31:24], rnd[22:20], 1'b1);
        end
        for (int v = 0; v < 120; v += 8) begin
            render_check("random", v);
        end
    endtask

    task automatic test_gate_and_clear();
        run_line(70);
        @(posedge clk);
        lvbl  <= 1'b0;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            if (!done) begin
                log_failure("scan started while lvbl was low");
            end
        end
        run_line(idle_line);
        read_line();
        model_line(70);
        compare_line("after gated start");
        expect_blank("second read");                // entries cleared by first read
    endtask

    initial begin
        rst      = 1'b1;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        start    = 1'b0;
        lvbl     = 1'b1;
        vrender  = '0;
        pxl_addr = 9'd511;
        for (int i = 0; i < obj_pkg::obj_count; i++) begin
            shadow[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        test_reset();
        test_axi_regs();
        test_single();
        test_sizes();
        test_overlap();
        test_random();
        test_gate_and_clear();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
